//--- design/dircc_packet_endpoint.sv
`timescale 1ns/1ns

module dircc_packet_endpoint #(
  parameter int INPUT_FIFO_DEPTH = 8
) (
  input  logic                           clk,
  input  logic                           reset_n,

  input  dircc_stream_pkg::stream_beat_t rx_beat,
  input  logic                           rx_valid,
  output logic                           rx_ready,

  input  logic                           read_packet,
  output logic                           packet_valid,
  output dircc_types_pkg::packet_t       packet_data,
  output logic                           receive_done,

  input  logic                           send_packet,
  input  dircc_types_pkg::packet_t       tx_packet,
  output logic                           tx_idle,

  output dircc_stream_pkg::stream_beat_t tx_beat,
  output logic                           tx_valid,
  input  logic                           tx_ready
);

  dircc_stream_pkg::stream_beat_t fifo_beat;  // FIFO head to deframer
  logic                           fifo_valid;
  logic                           fifo_ready;

  dircc_stream_fifo #(
    .DEPTH (INPUT_FIFO_DEPTH)
  ) input_fifo (
    .clk       (clk),
    .reset_n   (reset_n),
    .in_beat   (rx_beat),
    .in_valid  (rx_valid),
    .in_ready  (rx_ready),
    .out_beat  (fifo_beat),
    .out_valid (fifo_valid),
    .out_ready (fifo_ready)
  );

  dircc_packet_receiver receiver (
    .clk          (clk),
    .reset_n      (reset_n),
    .beat         (fifo_beat),
    .valid        (fifo_valid),
    .ready        (fifo_ready),
    .read_packet  (read_packet),
    .packet_valid (packet_valid),
    .packet_data  (packet_data),
    .receive_done (receive_done)
  );

  // transmit path is independent of the receive side
  dircc_packet_transmitter transmitter (
    .clk         (clk),
    .reset_n     (reset_n),
    .send_packet (send_packet),
    .tx_packet   (tx_packet),
    .tx_idle     (tx_idle),
    .beat        (tx_beat),
    .valid       (tx_valid),
    .ready       (tx_ready)
  );

endmodule : dircc_packet_endpoint

//--- design/dircc_packet_receiver.sv
`timescale 1ns/1ns

module dircc_packet_receiver (
  input  logic                           clk,
  input  logic                           reset_n,

  input  dircc_stream_pkg::stream_beat_t beat,
  input  logic                           valid,
  output logic                           ready,

  input  logic                           read_packet,
  output logic                           packet_valid,
  output dircc_types_pkg::packet_t       packet_data,
  output logic                           receive_done
);

  dircc_types_pkg::rx_mode_t      mode;
  dircc_types_pkg::packet_state_t state;
  dircc_types_pkg::packet_state_t next_state;
  dircc_types_pkg::packet_t       staging;  // record under assembly

  logic accept;
  logic last_beat;
  logic take;

  assign ready      = (mode == dircc_types_pkg::COLLECT);
  assign accept     = valid && ready;
  assign take       = read_packet && receive_done;  // reads while empty are dropped
  assign next_state = dircc_types_pkg::packet_state_t'(state + 3'd1);
  assign last_beat  = (state ==
    dircc_types_pkg::packet_state_t'(dircc_types_pkg::BEATS_PER_PACKET - 1));

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mode         <= dircc_types_pkg::COLLECT;
      state        <= dircc_types_pkg::DEST_ADDR0;
      receive_done <= 1'b0;
      packet_valid <= 1'b0;
    end else begin
      packet_valid <= take;  // single-cycle pulse
      if (take) begin
        mode         <= dircc_types_pkg::COLLECT;
        state        <= dircc_types_pkg::DEST_ADDR0;
        receive_done <= 1'b0;
      end else if (mode == dircc_types_pkg::HOLD) begin
        receive_done <= 1'b1;  // one cycle after the last beat
      end else if (accept) begin
        if (last_beat) begin
          mode  <= dircc_types_pkg::HOLD;
          state <= dircc_types_pkg::DEST_ADDR0;
        end else begin
          state <= next_state;
        end
      end
    end
  end

  // each beat lands in its own slice of the staging record
  always_ff @(posedge clk) begin
    if (accept) begin
      case (state)
        dircc_types_pkg::DEST_ADDR0: staging.dest_addr.hw_addr <= beat.data;
        dircc_types_pkg::DEST_ADDR1: begin
          {staging.dest_addr.sw_addr, staging.dest_addr.port,
           staging.dest_addr.flag} <= beat.data[31:8];  // low byte is padding
        end
        dircc_types_pkg::SRC_ADDR0:  staging.src_addr.hw_addr <= beat.data;
        dircc_types_pkg::SRC_ADDR1: begin
          {staging.src_addr.sw_addr, staging.src_addr.port,
           staging.src_addr.flag} <= beat.data[31:8];
        end
        dircc_types_pkg::LAMPORT:    staging.lamport      <= beat.data;
        dircc_types_pkg::DATA0:      staging.data[31:0]   <= beat.data;
        dircc_types_pkg::DATA1:      staging.data[63:32]  <= beat.data;
        dircc_types_pkg::DATA2:      staging.data[95:64]  <= beat.data;
      endcase
    end
    if (take) begin
      packet_data <= staging;  // held until the next read
    end
  end

  // framing from the far end of the link, only flagged
  a_sop_first: assert property (
    @(posedge clk) disable iff (!reset_n)
    accept && (state == dircc_types_pkg::DEST_ADDR0) |-> beat.startofpacket
  ) else $error("first beat of packet without startofpacket");

  a_eop_last: assert property (
    @(posedge clk) disable iff (!reset_n)
    accept && (state == dircc_types_pkg::DATA2) |-> beat.endofpacket
  ) else $error("last beat of packet without endofpacket");

  a_empty_zero: assert property (
    @(posedge clk) disable iff (!reset_n)
    accept |-> (beat.empty == '0)
  ) else $error("nonzero empty on accepted beat");

endmodule : dircc_packet_receiver

//--- design/dircc_packet_transmitter.sv
`timescale 1ns/1ns

module dircc_packet_transmitter (
  input  logic                           clk,
  input  logic                           reset_n,

  input  logic                           send_packet,
  input  dircc_types_pkg::packet_t       tx_packet,
  output logic                           tx_idle,

  output dircc_stream_pkg::stream_beat_t beat,
  output logic                           valid,
  input  logic                           ready
);

  dircc_types_pkg::packet_t       latched;
  dircc_types_pkg::packet_state_t state;  // beat now on the link
  dircc_types_pkg::packet_state_t next_state;

  logic start;
  logic advance;
  logic last_beat;

  // maps one packet position to its beat on the wire
  function automatic dircc_stream_pkg::stream_beat_t build_beat(
    input dircc_types_pkg::packet_t       p,
    input dircc_types_pkg::packet_state_t s
  );
    dircc_stream_pkg::stream_beat_t b;
    b.empty         = '0;
    b.startofpacket = (s == dircc_types_pkg::DEST_ADDR0);
    b.endofpacket   = (s == dircc_types_pkg::DATA2);
    case (s)
      dircc_types_pkg::DEST_ADDR0: b.data = p.dest_addr.hw_addr;
      dircc_types_pkg::DEST_ADDR1: begin
        b.data = {p.dest_addr.sw_addr, p.dest_addr.port, p.dest_addr.flag,
                  dircc_types_pkg::NULL_BYTE};
      end
      dircc_types_pkg::SRC_ADDR0:  b.data = p.src_addr.hw_addr;
      dircc_types_pkg::SRC_ADDR1: begin
        b.data = {p.src_addr.sw_addr, p.src_addr.port, p.src_addr.flag,
                  dircc_types_pkg::NULL_BYTE};
      end
      dircc_types_pkg::LAMPORT:    b.data = p.lamport;
      dircc_types_pkg::DATA0:      b.data = p.data[31:0];
      dircc_types_pkg::DATA1:      b.data = p.data[63:32];
      default:                     b.data = p.data[95:64];
    endcase
    return b;
  endfunction

  assign start      = send_packet && tx_idle;
  assign advance    = valid && ready;
  assign next_state = dircc_types_pkg::packet_state_t'(state + 3'd1);
  assign last_beat  = (state ==
    dircc_types_pkg::packet_state_t'(dircc_types_pkg::BEATS_PER_PACKET - 1));

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      tx_idle <= 1'b1;
      valid   <= 1'b0;
      state   <= dircc_types_pkg::DEST_ADDR0;
    end else if (start) begin
      tx_idle <= 1'b0;
      valid   <= 1'b1;
      state   <= dircc_types_pkg::DEST_ADDR0;
    end else if (advance) begin
      if (last_beat) begin
        valid   <= 1'b0;
        tx_idle <= 1'b1;  // ready for the next send
      end else begin
        state <= next_state;
      end
    end
  end

  // beat register only moves on a transfer, so it holds under back-pressure
  always_ff @(posedge clk) begin
    if (start) begin
      latched <= tx_packet;
      beat    <= build_beat(tx_packet, dircc_types_pkg::DEST_ADDR0);
    end else if (advance && !last_beat) begin
      beat <= build_beat(latched, next_state);
    end
  end

  a_send_when_idle: assert property (
    @(posedge clk) disable iff (!reset_n)
    send_packet |-> tx_idle
  ) else $error("send_packet while a packet is still going out");

endmodule : dircc_packet_transmitter

//--- design/dircc_stream_fifo.sv
`timescale 1ns/1ns

module dircc_stream_fifo #(
  parameter int DEPTH = 8
) (
  input  logic                           clk,
  input  logic                           reset_n,

  input  dircc_stream_pkg::stream_beat_t in_beat,
  input  logic                           in_valid,
  output logic                           in_ready,

  output dircc_stream_pkg::stream_beat_t out_beat,
  output logic                           out_valid,
  input  logic                           out_ready
);

  localparam int ADDR_WIDTH = $clog2(DEPTH);

  dircc_stream_pkg::stream_beat_t mem [DEPTH];

  logic [ADDR_WIDTH:0] wr_ptr;  // extra msb tells full from empty
  logic [ADDR_WIDTH:0] rd_ptr;
  logic [ADDR_WIDTH:0] count;
  logic                full;
  logic                push;
  logic                pop;

  assign count = wr_ptr - rd_ptr;
  assign full  = (count == DEPTH[ADDR_WIDTH:0]);

  // a full FIFO still takes a beat when the head leaves in the same cycle
  assign in_ready  = !full || out_ready;
  assign out_valid = (count != '0);
  assign out_beat  = mem[rd_ptr[ADDR_WIDTH-1:0]];  // show-ahead head entry

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr[ADDR_WIDTH-1:0]] <= in_beat;
    end
  end

  // occupancy must stay within the array
  a_no_overflow: assert property (
    @(posedge clk) disable iff (!reset_n)
    count <= DEPTH[ADDR_WIDTH:0]
  ) else $error("stream fifo occupancy above DEPTH");

endmodule : dircc_stream_fifo

//--- design/dircc_stream_pkg.sv
package dircc_stream_pkg;

  // fixed by the link format
  localparam int BEAT_WIDTH  = 32;
  localparam int EMPTY_WIDTH = 2;  // log2 of four symbols per beat

  // one beat of the streaming link, valid/ready travel beside it
  typedef struct packed {
    logic [BEAT_WIDTH-1:0]  data;
    logic [EMPTY_WIDTH-1:0] empty;          // always zero on this link
    logic                   startofpacket;
    logic                   endofpacket;
  } stream_beat_t;

endpackage : dircc_stream_pkg

//--- design/dircc_types_pkg.sv
package dircc_types_pkg;

  // one node address in the fabric
  typedef struct packed {
    logic [31:0] hw_addr;
    logic [15:0] sw_addr;
    logic [6:0]  port;
    logic        flag;
  } address_t;

  // 240-bit packet record as seen by the host side
  typedef struct packed {
    address_t    dest_addr;
    address_t    src_addr;
    logic [31:0] lamport;
    logic [95:0] data;
  } packet_t;

  localparam int         BEATS_PER_PACKET = 8;
  localparam logic [7:0] NULL_BYTE        = 8'h00;  // pad below each second address beat

  // beat position within a packet, same order on both directions
  typedef enum logic [2:0] {
    DEST_ADDR0,
    DEST_ADDR1,
    SRC_ADDR0,
    SRC_ADDR1,
    LAMPORT,
    DATA0,
    DATA1,
    DATA2
  } packet_state_t;

  typedef enum logic {
    COLLECT,  // taking beats from the FIFO
    HOLD      // full packet waiting for read_packet
  } rx_mode_t;

endpackage : dircc_types_pkg

//--- src.f
+incdir+include
design/dircc_stream_pkg.sv
design/dircc_types_pkg.sv
design/dircc_stream_fifo.sv
design/dircc_packet_receiver.sv
design/dircc_packet_transmitter.sv
design/dircc_packet_endpoint.sv
tb/tb_dircc_packet_endpoint.sv

//--- tb/dircc_packet_patterns.txt
# dest: hw sw port flag | src: hw sw port flag | lamport | data[31:0] data[63:32] data[95:64]
# all fields hex, port is 7 bits, flag is 1 bit
00000001 0001 01 0 00000002 0002 02 1 00000000 11111111 22222222 33333333
deadbeef cafe 7f 1 0badf00d beef 00 0 00000001 01234567 89abcdef fedcba98
ffffffff ffff 7f 1 ffffffff ffff 7f 1 ffffffff ffffffff ffffffff ffffffff
00000000 0000 00 0 00000000 0000 00 0 00000000 00000000 00000000 00000000
a5a5a5a5 5a5a 2a 1 5a5a5a5a a5a5 55 0 12345678 aaaaaaaa 55555555 aaaaaaaa
10203040 5060 10 0 70809000 a0b0 20 1 00000100 c0d0e0f0 01020304 05060708
80000000 8000 40 1 00000080 0080 01 0 7fffffff 80000001 40000002 20000004
13579bdf 2468 33 0 fdb97531 8642 66 1 00000abc 0f0f0f0f f0f0f0f0 00ff00ff
00c0ffee 00aa 0c 1 00facade 0055 0d 0 0000ffff 11223344 55667788 99aabbcc
76543210 3210 76 0 01234567 4567 01 1 00010000 deadc0de feedface 8badf00d
00000bad 0bad 3b 1 00000f00 0f00 4f 0 abcdef01 0000abcd 00ef0000 12000034
5eed0085 0085 55 0 85005eed 5e00 2e 1 00000055 00000085 85000000 00850085

//--- include/dircc_tb_checks.svh
`ifndef DIRCC_TB_CHECKS_SVH
`define DIRCC_TB_CHECKS_SVH

// report the first mismatch and end the run
task automatic fail_stop(input string name, input string exp_s, input string act_s);
  $display("FAIL at %0t: %s expected %s actual %s", $time, name, exp_s, act_s);
  $display("Simulation failed");
  $fatal(1);
endtask

task automatic check_packet(
  input string                    name,
  input dircc_types_pkg::packet_t exp,
  input dircc_types_pkg::packet_t act
);
  if (act !== exp) begin
    fail_stop(name, $sformatf("%h", exp), $sformatf("%h", act));
  end
endtask

// data, empty, sop and eop in one compare
task automatic check_beat(
  input string                          name,
  input dircc_stream_pkg::stream_beat_t exp,
  input dircc_stream_pkg::stream_beat_t act
);
  if (act !== exp) begin
    fail_stop(name, $sformatf("%h", exp), $sformatf("%h", act));
  end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    fail_stop(name, $sformatf("%b", exp), $sformatf("%b", act));
  end
endtask

`endif

//--- tb/tb_dircc_packet_endpoint.sv
`timescale 1ns/1ns

module tb_dircc_packet_endpoint;

  localparam int FIFO_DEPTH = 8;  // two packets fill it with the first one held

  logic                           clk;
  logic                           reset_n;
  dircc_stream_pkg::stream_beat_t rx_beat;
  logic                           rx_valid;
  logic                           rx_ready;
  logic                           read_packet;
  logic                           packet_valid;
  dircc_types_pkg::packet_t       packet_data;
  logic                           receive_done;
  logic                           send_packet;
  dircc_types_pkg::packet_t       tx_packet;
  logic                           tx_idle;
  dircc_stream_pkg::stream_beat_t tx_beat;
  logic                           tx_valid;
  logic                           tx_ready;

  dircc_types_pkg::packet_t pkts [$];  // one entry per pattern line
  int cycles      = 0;
  int cycle_limit = 0;
  int reads_done  = 0;
  int pulses_seen = 0;

  `include "dircc_tb_checks.svh"

  dircc_packet_endpoint #(
    .INPUT_FIFO_DEPTH (FIFO_DEPTH)
  ) uut (
    .clk          (clk),
    .reset_n      (reset_n),
    .rx_beat      (rx_beat),
    .rx_valid     (rx_valid),
    .rx_ready     (rx_ready),
    .read_packet  (read_packet),
    .packet_valid (packet_valid),
    .packet_data  (packet_data),
    .receive_done (receive_done),
    .send_packet  (send_packet),
    .tx_packet    (tx_packet),
    .tx_idle      (tx_idle),
    .tx_beat      (tx_beat),
    .tx_valid     (tx_valid),
    .tx_ready     (tx_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("Timeout: run went past %0d cycles without finishing", cycle_limit);
      $display("Simulation failed");
      $fatal(1);
    end
  end

  always @(posedge clk) begin
    if (reset_n && packet_valid) begin
      pulses_seen <= pulses_seen + 1;  // every pulse, wanted or not
    end
  end

  // beat layout of the packet format, beat 0 first
  function automatic dircc_stream_pkg::stream_beat_t expected_beat(
    input dircc_types_pkg::packet_t p,
    input int                       idx
  );
    logic [31:0] words [0:7];
    dircc_stream_pkg::stream_beat_t b;
    words[0] = p.dest_addr.hw_addr;
    words[1] = {p.dest_addr.sw_addr, p.dest_addr.port, p.dest_addr.flag, 8'h00};
    words[2] = p.src_addr.hw_addr;
    words[3] = {p.src_addr.sw_addr, p.src_addr.port, p.src_addr.flag, 8'h00};
    words[4] = p.lamport;
    words[5] = p.data[31:0];
    words[6] = p.data[63:32];
    words[7] = p.data[95:64];
    b.data          = words[idx];
    b.empty         = 2'b00;
    b.startofpacket = (idx == 0);
    b.endofpacket   = (idx == 7);
    return b;
  endfunction

  task automatic load_patterns();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f [0:11];
    dircc_types_pkg::packet_t p;
    fd = $fopen("tb/dircc_packet_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open the pattern file tb/dircc_packet_patterns.txt");
      $display("Simulation failed");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.substr(0, 0) == "#") begin
        continue;  // comment or blank line
      end
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                  f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
      if (n != 12) begin
        continue;
      end
      p.dest_addr.hw_addr = f[0];
      p.dest_addr.sw_addr = f[1][15:0];
      p.dest_addr.port    = f[2][6:0];
      p.dest_addr.flag    = f[3][0];
      p.src_addr.hw_addr  = f[4];
      p.src_addr.sw_addr  = f[5][15:0];
      p.src_addr.port     = f[6][6:0];
      p.src_addr.flag     = f[7][0];
      p.lamport           = f[8];
      p.data              = {f[11], f[10], f[9]};
      pkts.push_back(p);
    end
    $fclose(fd);
  endtask

  // called at a clock edge, returns at the edge of the last transfer
  task automatic drive_rx_packet(input dircc_types_pkg::packet_t p, input bit gaps);
    int g;
    for (int i = 0; i < 8; i++) begin
      g = (gaps && ($urandom % 4 == 0)) ? 1 + ($urandom % 2) : 0;
      if (g > 0) begin
        rx_valid <= 1'b0;  // idle gap on the link
        repeat (g) @(posedge clk);
      end
      rx_beat  <= expected_beat(p, i);
      rx_valid <= 1'b1;
      @(posedge clk);
      while (!rx_ready) @(posedge clk);  // held by back-pressure
    end
    rx_valid <= 1'b0;
  endtask

  task automatic read_rx_packet(input dircc_types_pkg::packet_t exp);
    @(posedge clk);
    while (!receive_done) @(posedge clk);
    repeat ($urandom % 4) @(posedge clk);
    read_packet <= 1'b1;
    @(posedge clk);
    check_bit("packet_valid", 1'b0, packet_valid);
    read_packet <= 1'b0;
    @(posedge clk);
    check_bit("packet_valid", 1'b1, packet_valid);
    check_bit("receive_done", 1'b0, receive_done);
    check_packet("packet_data", exp, packet_data);
    @(posedge clk);
    check_bit("packet_valid", 1'b0, packet_valid);  // single pulse
    reads_done++;
  endtask

  task automatic run_tx_packet(input dircc_types_pkg::packet_t p);
    int                             i;
    bit                             stalled;
    dircc_stream_pkg::stream_beat_t held;
    while (!tx_idle) @(posedge clk);
    tx_packet   <= p;
    send_packet <= 1'b1;
    @(posedge clk);
    send_packet <= 1'b0;
    tx_ready    <= ($urandom % 2) == 0;
    i       = 0;
    stalled = 1'b0;
    while (i < 8) begin
      @(posedge clk);
      check_bit("tx_valid", 1'b1, tx_valid);
      check_bit("tx_idle", 1'b0, tx_idle);
      if (stalled) begin
        check_beat("tx_beat (stalled)", held, tx_beat);  // frozen while not ready
      end
      if (tx_ready) begin
        check_beat("tx_beat", expected_beat(p, i), tx_beat);
        i++;
        stalled = 1'b0;
      end else begin
        held    = tx_beat;
        stalled = 1'b1;
      end
      tx_ready <= ($urandom % 2) == 0;
    end
    @(posedge clk);
    check_bit("tx_idle", 1'b1, tx_idle);
    check_bit("tx_valid", 1'b0, tx_valid);
  endtask

  initial begin
    void'($urandom(85));
    reset_n     = 1'b0;
    rx_beat     = '0;
    rx_valid    = 1'b0;
    read_packet = 1'b0;
    send_packet = 1'b0;
    tx_packet   = '0;
    tx_ready    = 1'b0;
    load_patterns();
    if (pkts.size() == 0) begin
      $display("pattern file holds no packets");
      $display("Simulation failed");
      $fatal(1);
    end
    cycle_limit = pkts.size() * 120 + 200;

    repeat (2) @(posedge clk);
    reset_n <= 1'b1;
    @(posedge clk);
    check_bit("rx_ready", 1'b1, rx_ready);
    check_bit("tx_idle", 1'b1, tx_idle);
    check_bit("fifo_valid", 1'b0, uut.fifo_valid);
    check_bit("receive_done", 1'b0, receive_done);
    check_bit("packet_valid", 1'b0, packet_valid);
    check_bit("tx_valid", 1'b0, tx_valid);

    // receive with random gaps and read delays
    foreach (pkts[k]) begin
      fork
        drive_rx_packet(pkts[k], 1'b1);
        read_rx_packet(pkts[k]);
      join
    end

    // two packets, no reads, FIFO must stall the link
    drive_rx_packet(pkts[0], 1'b0);
    drive_rx_packet(pkts[1], 1'b0);
    @(posedge clk);
    check_bit("rx_ready", 1'b0, rx_ready);  // second packet fills the FIFO exactly
    read_rx_packet(pkts[0]);
    read_rx_packet(pkts[1]);

    foreach (pkts[k]) begin
      run_tx_packet(pkts[k]);
    end

    // both directions at once, different packet order
    fork
      begin
        foreach (pkts[k]) begin
          fork
            drive_rx_packet(pkts[k], 1'b1);
            read_rx_packet(pkts[k]);
          join
        end
      end
      begin
        for (int k = pkts.size() - 1; k >= 0; k--) begin
          run_tx_packet(pkts[k]);
        end
      end
    join

    repeat (2) @(posedge clk);
    if (pulses_seen != reads_done) begin
      $display("packet_valid pulsed %0d times for %0d reads", pulses_seen, reads_done);
      $display("Simulation failed");
      $fatal(1);
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule : tb_dircc_packet_endpoint
